//--- source/cpu_pkg.sv
// bus widths, reset pc, opcode and function codes, execute states, instruction word union
`default_nettype none

package cpu_pkg;

    localparam int xlen      = 32;
    localparam int sel_width = 4;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // funct field of r-type
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;

    // execute fsm encoding
    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_mem_wait   = 2'd1;
    localparam logic [1:0] st_write_back = 2'd2;

    // one instruction word, seen as r-type or i-type fields
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

//--- source/mem_bus_if.sv
// wishbone classic single-beat bus with requester and arbiter modports
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic [cpu_pkg::xlen-1:0]      adr;
    logic [cpu_pkg::xlen-1:0]      wdata;
    logic [cpu_pkg::xlen-1:0]      rdata;
    logic [cpu_pkg::sel_width-1:0] sel;
    logic                          we;
    logic                          cyc;
    logic                          stb;
    logic                          ack;   // one cycle per access

    modport requester (
        output adr, wdata, sel, we, cyc, stb,
        input  rdata, ack
    );

    modport arbiter (
        input  adr, wdata, sel, we, cyc, stb,
        output rdata, ack
    );

endinterface

`default_nettype wire

//--- source/fetch_unit.sv
// fetch unit: next-fetch pc, prefetch request, one-entry instruction buffer, branch squash
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                     clk,
    input  wire logic                     reset,
    mem_bus_if.requester                  bus,
    input  wire logic                     take,
    input  wire logic                     redirect,
    input  wire logic [cpu_pkg::xlen-1:0] redirect_pc,
    output logic                          instr_valid,
    output cpu_pkg::instr_t               instr,
    output logic [cpu_pkg::xlen-1:0]      instr_pc
);

    logic [cpu_pkg::xlen-1:0] pc;        // next word to fetch
    logic [cpu_pkg::xlen-1:0] req_adr;
    logic [cpu_pkg::xlen-1:0] buf_pc;
    cpu_pkg::instr_t          buf_instr;
    logic                     buf_valid;
    logic                     req;
    logic                     drop;      // in-flight fetch is stale
    logic                     issue;
    logic                     acked;

    assign acked = req && bus.ack;
    // only when the buffer will be free, never on a redirect cycle
    assign issue = !req && (!buf_valid || take) && !redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= cpu_pkg::reset_pc;
            buf_valid <= 1'b0;
            req       <= 1'b0;
            drop      <= 1'b0;
        end else begin
            if (issue)
                req <= 1'b1;
            else if (acked)
                req <= 1'b0;   // cyc falls the cycle after ack

            if (redirect) begin
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
                drop      <= req && !bus.ack;
            end else begin
                if (take)
                    buf_valid <= 1'b0;
                if (acked) begin
                    if (drop) begin
                        drop <= 1'b0;
                    end else begin
                        buf_valid <= 1'b1;
                        pc        <= req_adr + 32'd4;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            req_adr <= pc;
        if (acked) begin
            buf_instr <= bus.rdata;
            buf_pc    <= req_adr;
        end
    end

    assign bus.cyc   = req;
    assign bus.stb   = req;
    assign bus.adr   = req_adr;
    assign bus.we    = 1'b0;       // reads only
    assign bus.sel   = '1;
    assign bus.wdata = '0;

    assign instr_valid = buf_valid;
    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;

endmodule

`default_nettype wire

//--- source/core_execute.sv
// execute stage: register file, decode, alu, beq resolution, load/store issue, write-back trace
`timescale 1ns/1ps
`default_nettype none

module core_execute (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     instr_valid,
    input  wire cpu_pkg::instr_t          instr,
    input  wire logic [cpu_pkg::xlen-1:0] instr_pc,
    output logic                          take,
    output logic                          redirect,
    output logic [cpu_pkg::xlen-1:0]      redirect_pc,
    output logic                          ls_start,
    output logic [cpu_pkg::xlen-1:0]      ls_addr,
    output logic                          ls_store,
    output logic [cpu_pkg::xlen-1:0]      ls_store_data,
    input  wire logic                     ls_done,
    input  wire logic [cpu_pkg::xlen-1:0] ls_load_data,
    output logic [cpu_pkg::xlen-1:0]      debug_wb_pc,
    output logic [cpu_pkg::xlen-1:0]      debug_wb_rf_wdata,
    output logic [3:0]                    debug_wb_rf_wen,
    output logic [4:0]                    debug_wb_rf_wnum
);

    logic [cpu_pkg::xlen-1:0] regs [32];
    logic [1:0]               state;
    cpu_pkg::instr_t          ir;
    cpu_pkg::instr_t          cur;          // word being decoded this cycle
    logic [cpu_pkg::xlen-1:0] ir_pc;
    logic [cpu_pkg::xlen-1:0] rs_val;
    logic [cpu_pkg::xlen-1:0] rt_val;
    logic [cpu_pkg::xlen-1:0] imm_sext;
    logic [cpu_pkg::xlen-1:0] wb_data;
    logic [4:0]               wb_num;
    logic                     wb_en;
    logic                     rf_wen;
    logic                     is_mem;

    assign take = (state == cpu_pkg::st_idle) && instr_valid;

    // idle decodes the incoming word, later states the held one
    assign cur = (state == cpu_pkg::st_idle) ? instr : ir;

    assign rs_val   = (cur.i.rs == 5'd0) ? '0 : regs[cur.i.rs];
    assign rt_val   = (cur.i.rt == 5'd0) ? '0 : regs[cur.i.rt];
    assign imm_sext = {{16{cur.i.imm[15]}}, cur.i.imm};
    assign is_mem   = (cur.i.op == cpu_pkg::op_lw) || (cur.i.op == cpu_pkg::op_sw);

    always_comb begin
        wb_en   = 1'b0;
        wb_num  = cur.i.rt;
        wb_data = rs_val + imm_sext;
        case (cur.i.op)
            cpu_pkg::op_rtype: begin
                wb_num = cur.r.rd;   // r-type view
                if (cur.r.funct == cpu_pkg::fn_addu) begin
                    wb_en   = 1'b1;
                    wb_data = rs_val + rt_val;
                end else if (cur.r.funct == cpu_pkg::fn_subu) begin
                    wb_en   = 1'b1;
                    wb_data = rs_val - rt_val;
                end
            end
            cpu_pkg::op_addiu: wb_en = 1'b1;
            cpu_pkg::op_lui: begin
                wb_en   = 1'b1;
                wb_data = {cur.i.imm, 16'h0000};
            end
            cpu_pkg::op_lw: begin
                wb_en   = 1'b1;
                wb_data = ls_load_data;   // held by the lsu after done
            end
            default: wb_en = 1'b0;
        endcase
    end

    assign rf_wen = (state == cpu_pkg::st_write_back) && wb_en && (wb_num != 5'd0);

    // beq resolves in the cycle after take
    assign redirect    = (state == cpu_pkg::st_write_back) && (cur.i.op == cpu_pkg::op_beq)
                         && (rs_val == rt_val);
    assign redirect_pc = ir_pc + 32'd4 + {imm_sext[cpu_pkg::xlen-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cpu_pkg::st_idle;
            ls_start <= 1'b0;
        end else begin
            ls_start <= 1'b0;
            case (state)
                cpu_pkg::st_idle: begin
                    if (take) begin
                        ls_start <= is_mem;
                        state    <= is_mem ? cpu_pkg::st_mem_wait : cpu_pkg::st_write_back;
                    end
                end
                cpu_pkg::st_mem_wait: begin
                    if (ls_done)   // sw has nothing to write back
                        state <= (cur.i.op == cpu_pkg::op_sw) ? cpu_pkg::st_idle
                                                              : cpu_pkg::st_write_back;
                end
                default: state <= cpu_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ir            <= instr;
            ir_pc         <= instr_pc;
            ls_addr       <= rs_val + imm_sext;
            ls_store      <= (instr.i.op == cpu_pkg::op_sw);
            ls_store_data <= rt_val;
        end
        if (rf_wen)
            regs[wb_num] <= wb_data;
    end

    assign debug_wb_pc       = ir_pc;
    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wen   = {4{rf_wen}};
    assign debug_wb_rf_wnum  = wb_num;

endmodule

`default_nettype wire

//--- source/load_store_unit.sv
// load/store unit: one held word access on the data bus with load data return
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  wire logic                     clk,
    input  wire logic                     reset,
    mem_bus_if.requester                  bus,
    input  wire logic                     start,
    input  wire logic [cpu_pkg::xlen-1:0] addr,
    input  wire logic                     store,
    input  wire logic [cpu_pkg::xlen-1:0] store_data,
    output logic                          done,
    output logic [cpu_pkg::xlen-1:0]      load_data
);

    logic                     req;
    logic                     req_we;
    logic [cpu_pkg::xlen-1:0] req_adr;
    logic [cpu_pkg::xlen-1:0] req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            req  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= req && bus.ack;   // one-cycle pulse after ack
            if (start)
                req <= 1'b1;
            else if (bus.ack)
                req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_adr   <= addr;
            req_we    <= store;
            req_wdata <= store_data;
        end
        if (req && bus.ack && !req_we)
            load_data <= bus.rdata;
    end

    assign bus.cyc   = req;
    assign bus.stb   = req;
    assign bus.adr   = req_adr;
    assign bus.we    = req_we;
    assign bus.wdata = req_wdata;
    assign bus.sel   = '1;          // whole words only

endmodule

`default_nettype wire

//--- source/bus_arbiter.sv
// bus arbiter: shares the external wishbone bus between data and fetch requesters
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic                          clk,
    input  wire logic                          reset,
    mem_bus_if.arbiter                         data_port,
    mem_bus_if.arbiter                         fetch_port,
    output logic [cpu_pkg::xlen-1:0]           bus_adr,
    output logic [cpu_pkg::xlen-1:0]           bus_wdata,
    output logic [cpu_pkg::sel_width-1:0]      bus_sel,
    output logic                               bus_we,
    output logic                               bus_cyc,
    output logic                               bus_stb,
    input  wire logic                          bus_ack,
    input  wire logic [cpu_pkg::xlen-1:0]      bus_rdata
);

    logic busy;       // a requester owns the bus
    logic own_data;   // owner is the data side
    logic own_cyc;

    assign own_cyc = own_data ? data_port.cyc : fetch_port.cyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            own_data <= 1'b0;
        end else if (!busy) begin
            if (data_port.cyc) begin   // execute is stalled on it
                busy     <= 1'b1;
                own_data <= 1'b1;
            end else if (fetch_port.cyc) begin
                busy     <= 1'b1;
                own_data <= 1'b0;
            end
        end else if (!own_cyc) begin
            busy <= 1'b0;
        end
    end

    assign bus_cyc   = busy && own_cyc;
    assign bus_stb   = busy && (own_data ? data_port.stb : fetch_port.stb);
    assign bus_adr   = own_data ? data_port.adr   : fetch_port.adr;
    assign bus_wdata = own_data ? data_port.wdata : fetch_port.wdata;
    assign bus_sel   = own_data ? data_port.sel   : fetch_port.sel;
    assign bus_we    = own_data ? data_port.we    : fetch_port.we;

    // the waiting side never sees ack
    assign data_port.ack  = busy && own_data && bus_ack;
    assign fetch_port.ack = busy && !own_data && bus_ack;

    assign data_port.rdata  = bus_rdata;
    assign fetch_port.rdata = bus_rdata;

endmodule

`default_nettype wire

//--- source/mycpu_top.sv
// cpu top level: fetch, execute, load/store and arbiter on one wishbone bus, debug trace ports
`timescale 1ns/1ps
`default_nettype none

module mycpu_top (
    input  wire logic                          aclk,
    input  wire logic                          reset,
    output logic [cpu_pkg::xlen-1:0]           bus_adr,
    output logic [cpu_pkg::xlen-1:0]           bus_wdata,
    input  wire logic [cpu_pkg::xlen-1:0]      bus_rdata,
    output logic [cpu_pkg::sel_width-1:0]      bus_sel,
    output logic                               bus_we,
    output logic                               bus_cyc,
    output logic                               bus_stb,
    input  wire logic                          bus_ack,
    output logic [cpu_pkg::xlen-1:0]           debug_wb_pc,
    output logic [cpu_pkg::xlen-1:0]           debug_wb_rf_wdata,
    output logic [3:0]                         debug_wb_rf_wen,
    output logic [4:0]                         debug_wb_rf_wnum
);

    logic                     instr_valid;
    cpu_pkg::instr_t          instr;
    logic [cpu_pkg::xlen-1:0] instr_pc;
    logic                     take;
    logic                     redirect;
    logic [cpu_pkg::xlen-1:0] redirect_pc;
    logic                     ls_start;
    logic [cpu_pkg::xlen-1:0] ls_addr;
    logic                     ls_store;
    logic [cpu_pkg::xlen-1:0] ls_store_data;
    logic                     ls_done;
    logic [cpu_pkg::xlen-1:0] ls_load_data;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    fetch_unit u_fetch (
        .clk         (aclk),
        .reset       (reset),
        .bus         (fetch_bus.requester),
        .take        (take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    core_execute u_execute (
        .clk               (aclk),
        .reset             (reset),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .instr_pc          (instr_pc),
        .take              (take),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .ls_start          (ls_start),
        .ls_addr           (ls_addr),
        .ls_store          (ls_store),
        .ls_store_data     (ls_store_data),
        .ls_done           (ls_done),
        .ls_load_data      (ls_load_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    load_store_unit u_lsu (
        .clk        (aclk),
        .reset      (reset),
        .bus        (data_bus.requester),
        .start      (ls_start),
        .addr       (ls_addr),
        .store      (ls_store),
        .store_data (ls_store_data),
        .done       (ls_done),
        .load_data  (ls_load_data)
    );

    bus_arbiter u_arbiter (
        .clk        (aclk),
        .reset      (reset),
        .data_port  (data_bus.arbiter),
        .fetch_port (fetch_bus.arbiter),
        .bus_adr    (bus_adr),
        .bus_wdata  (bus_wdata),
        .bus_sel    (bus_sel),
        .bus_we     (bus_we),
        .bus_cyc    (bus_cyc),
        .bus_stb    (bus_stb),
        .bus_ack    (bus_ack),
        .bus_rdata  (bus_rdata)
    );

endmodule

`default_nettype wire

//--- dv/cpu_props.sv
// bound bus protocol and reset state assertions for the cpu top level
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
    input wire logic                          clk,
    input wire logic                          reset,
    input wire logic [cpu_pkg::xlen-1:0]      bus_adr,
    input wire logic [cpu_pkg::xlen-1:0]      bus_wdata,
    input wire logic [cpu_pkg::sel_width-1:0] bus_sel,
    input wire logic                          bus_we,
    input wire logic                          bus_cyc,
    input wire logic                          bus_stb,
    input wire logic                          bus_ack,
    input wire logic [3:0]                    debug_wb_rf_wen
);

    int unsigned reset_fails    = 0;
    int unsigned protocol_fails = 0;
    logic        first_done;   // first bus access has been acked

    always @(posedge clk) begin
        if (reset)
            first_done <= 1'b0;
        else if (bus_cyc && bus_ack)
            first_done <= 1'b1;
    end

    // first cycle after reset is quiet
    reset_idle: assert property (@(posedge clk)
        $fell(reset) |-> !bus_cyc && !bus_stb && (debug_wb_rf_wen == 4'h0))
        else begin
            $error("bus or trace active in the first cycle after reset");
            reset_fails++;
        end

    first_fetch: assert property (@(posedge clk) disable iff (reset)
        (bus_cyc && bus_stb && !first_done) |-> (bus_adr == cpu_pkg::reset_pc) && !bus_we)
        else begin
            $error("first bus request is not a read of the reset pc");
            reset_fails++;
        end

    stb_inside_cyc: assert property (@(posedge clk) bus_stb |-> bus_cyc)
        else begin
            $error("stb high without cyc");
            protocol_fails++;
        end

    // request fields held until ack
    held_while_waiting: assert property (@(posedge clk) disable iff (reset)
        (bus_stb && !bus_ack) |=> $stable(bus_adr) && $stable(bus_we)
                                  && $stable(bus_sel) && $stable(bus_wdata))
        else begin
            $error("request changed before ack");
            protocol_fails++;
        end

endmodule

bind mycpu_top cpu_props props (
    .clk             (aclk),
    .reset           (reset),
    .bus_adr         (bus_adr),
    .bus_wdata       (bus_wdata),
    .bus_sel         (bus_sel),
    .bus_we          (bus_we),
    .bus_cyc         (bus_cyc),
    .bus_stb         (bus_stb),
    .bus_ack         (bus_ack),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

`default_nettype wire

//--- dv/tb_top.sv
// testbench: clock, reset, wishbone memory with wait states, program image, trace and store checks
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int trace_len      = 10;
    localparam int timeout_cycles = 30 * trace_len + 200;
    localparam int mem_words      = 128;
    localparam int prog_len       = 17;

    localparam logic [31:0] store_adr  = 32'h0000_0108;
    localparam logic [31:0] store_data = 32'h1234_567d;

    localparam logic [31:0] program_image [prog_len] = '{
        32'h2401_0005,   // 00 addiu $1, $0, 5
        32'h3c02_1234,   // 04 lui   $2, 0x1234
        32'h2442_5678,   // 08 addiu $2, $2, 0x5678
        32'h0022_1821,   // 0c addu  $3, $1, $2
        32'h0061_2023,   // 10 subu  $4, $3, $1
        32'h2405_ffff,   // 14 addiu $5, $0, -1
        32'h2406_0100,   // 18 addiu $6, $0, 0x100
        32'hacc3_0008,   // 1c sw    $3, 8($6)
        32'h8cc7_0008,   // 20 lw    $7, 8($6)
        32'h2400_0007,   // 24 addiu $0, $0, 7 (dropped)
        32'h1082_0002,   // 28 beq   $4, $2, +2 (taken)
        32'h2408_0011,   // 2c skipped
        32'h2409_0022,   // 30 skipped
        32'h1022_0001,   // 34 beq   $1, $2, +1 (falls through)
        32'h240a_0033,   // 38 addiu $10, $0, 0x33
        32'h00a7_5823,   // 3c subu  $11, $5, $7
        32'h1000_ffff    // 40 beq   $0, $0, -1 (park)
    };

    // expected trace, category 0 alu, 1 store/load, 2 beq
    localparam logic [31:0] exp_pc [trace_len] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h20, 32'h38, 32'h3c
    };
    localparam logic [4:0] exp_num [trace_len] = '{
        5'd1, 5'd2, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd10, 5'd11
    };
    localparam logic [31:0] exp_data [trace_len] = '{
        32'h0000_0005, 32'h1234_0000, 32'h1234_5678, 32'h1234_567d, 32'h1234_5678,
        32'hffff_ffff, 32'h0000_0100, 32'h1234_567d, 32'h0000_0033, 32'hedcb_a982
    };
    localparam int exp_cat [trace_len] = '{0, 0, 0, 0, 0, 0, 0, 1, 2, 2};

    logic        clk;
    logic        reset;
    logic [31:0] bus_adr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic [3:0]  bus_sel;
    logic        bus_we;
    logic        bus_cyc;
    logic        bus_stb;
    logic        bus_ack;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] mem [mem_words];
    integer      seed;
    integer      rnd;
    logic        in_wait;
    logic [1:0]  wait_left;
    int          cycles;
    int          trace_idx;
    int          stores_seen;
    int          extra_writes;
    int          stalled;
    int          checks [3];
    int          fails [3];
    int          total_checks;
    int          total_fails;

    mycpu_top DUT (
        .aclk              (clk),
        .reset             (reset),
        .bus_adr           (bus_adr),
        .bus_wdata         (bus_wdata),
        .bus_rdata         (bus_rdata),
        .bus_sel           (bus_sel),
        .bus_we            (bus_we),
        .bus_cyc           (bus_cyc),
        .bus_stb           (bus_stb),
        .bus_ack           (bus_ack),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    function automatic string test_name(input int cat);
        case (cat)
            0: return "alu_results";
            1: return "store_load";
            default: return "beq_flow";
        endcase
    endfunction

    function automatic int last_index(input int cat);
        int last;
        last = -1;
        for (int i = 0; i < trace_len; i++)
            if (exp_cat[i] == cat)
                last = i;
        return last;
    endfunction

    // answers the pending access, byte selects honored on writes
    task automatic complete_access();
        logic [6:0]  idx;
        logic [31:0] word;
        idx  = bus_adr[8:2];
        word = mem[idx];
        bus_ack   <= 1'b1;
        bus_rdata <= word;
        if (bus_we) begin
            for (int b = 0; b < 4; b++)
                if (bus_sel[b])
                    word[8*b +: 8] = bus_wdata[8*b +: 8];
            mem[idx] <= word;
        end
    endtask

    // memory model, 0 to 3 wait states per access
    always @(posedge clk) begin
        if (reset) begin
            bus_ack <= 1'b0;
            in_wait <= 1'b0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;
        end else if (bus_cyc && bus_stb) begin
            if (!in_wait) begin
                rnd = $random(seed);
                if (rnd[1:0] == 2'd0) begin
                    complete_access();
                end else begin
                    in_wait   <= 1'b1;
                    wait_left <= rnd[1:0] - 2'd1;
                end
            end else if (wait_left == 2'd0) begin
                in_wait <= 1'b0;
                complete_access();
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    task automatic report_test(input int cat);
        if (cat == 1) begin
            one_store: assert (stores_seen == 1)
                else begin
                    $display("store_load: expected one bus write for the sw, saw %0d",
                             stores_seen);
                    fails[1]++;
                end
        end
        $display("test %s finished: %0d checks, %0d failures",
                 test_name(cat), checks[cat], fails[cat]);
    endtask

    task automatic check_trace_entry();
        int cat;
        in_range: assert (trace_idx < trace_len)
            else begin
                $display("unexpected write-back of r%0d at pc %h after the last trace entry",
                         debug_wb_rf_wnum, debug_wb_pc);
                extra_writes++;
            end
        if (trace_idx < trace_len) begin
            cat = exp_cat[trace_idx];
            checks[cat]++;
            entry_match: assert (debug_wb_pc == exp_pc[trace_idx]
                                 && debug_wb_rf_wnum == exp_num[trace_idx]
                                 && debug_wb_rf_wdata == exp_data[trace_idx]
                                 && debug_wb_rf_wen == 4'hf)
                else begin
                    $display("error %s: entry %0d expected pc %h r%0d %h wen f, %s %h r%0d %h wen %h",
                             test_name(cat), trace_idx, exp_pc[trace_idx], exp_num[trace_idx],
                             exp_data[trace_idx], "got pc", debug_wb_pc, debug_wb_rf_wnum,
                             debug_wb_rf_wdata, debug_wb_rf_wen);
                    fails[cat]++;
                end
            if (trace_idx == last_index(cat))
                report_test(cat);
        end
    endtask

    task automatic check_store();
        stores_seen++;
        checks[1]++;
        store_match: assert (bus_adr == store_adr && bus_wdata == store_data && bus_sel == 4'hf)
            else begin
                $display("error store_load: expected write %h <- %h sel f, got %h <- %h sel %h",
                         store_adr, store_data, bus_adr, bus_wdata, bus_sel);
                fails[1]++;
            end
    endtask

    always @(posedge clk) begin
        if (!reset && debug_wb_rf_wen != 4'h0) begin
            check_trace_entry();
            trace_idx <= trace_idx + 1;
        end
        if (!reset && bus_cyc && bus_stb && bus_ack && bus_we)
            check_store();
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        bus_ack      = 1'b0;
        bus_rdata    = '0;
        seed         = 76673;
        cycles       = 0;
        trace_idx    = 0;
        stores_seen  = 0;
        extra_writes = 0;
        stalled      = 0;
        for (int c = 0; c < 3; c++) begin
            checks[c] = 0;
            fails[c]  = 0;
        end
        for (int i = 0; i < mem_words; i++)
            mem[i] = 32'hbad0_0000 | (i << 2);   // byte address in the low half
        for (int i = 0; i < prog_len; i++)
            mem[i] = program_image[i];

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (trace_idx < trace_len && cycles < timeout_cycles)
            @(posedge clk);
        repeat (4) @(posedge clk);

        trace_done: assert (trace_idx >= trace_len)
            else begin
                $display("completion: the trace stalled after %0d of %0d entries in %0d cycles",
                         trace_idx, trace_len, cycles);
                stalled = 1;
            end
        $display("test completion finished: %0d of %0d entries", trace_idx, trace_len);
        $display("test reset_state finished: %0d failures", DUT.props.reset_fails);
        $display("test bus_protocol finished: %0d failures", DUT.props.protocol_fails);

        total_checks = checks[0] + checks[1] + checks[2] + 1;
        total_fails  = fails[0] + fails[1] + fails[2] + extra_writes + stalled
                       + DUT.props.reset_fails + DUT.props.protocol_fails;
        $display("checks: %0d, failures: %0d", total_checks, total_fails);
        if (total_fails == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/cpu_pkg.sv
source/mem_bus_if.sv
source/fetch_unit.sv
source/core_execute.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/mycpu_top.sv
dv/cpu_props.sv
dv/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cpu testbench with verilator, runs it and checks the result
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_top -f sources.f -o sim_tb; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+100)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
